// File: src/tanh_defines.svh
// Tanh activation stage parameters
// Q4.12 element format, vector length width and divider width

`ifndef TANH_DEFINES_SVH
`define TANH_DEFINES_SVH

// Element word, signed Q4.12
`define TANH_DATA_SIZE 16
`define TANH_FRAC_BITS 12

// Vector length field, 1 to 255 elements
`define TANH_SIZE_BITS 8

// Fixed-point constants
`define TANH_ONE       4096
`define TANH_SAT_LIMIT 12288

// Unsigned operand width inside the divider
`define TANH_DIV_BITS  32

`endif

// File: src/tanh_pkg.sv
// Shared types for the tanh activation stage
// Element streams plus scalar and divider request/response pairs

`include "tanh_defines.svh"

package tanh_pkg;

  // Signed Q4.12 word
  typedef logic signed [`TANH_DATA_SIZE-1:0] fixp_t;

  // Element stream, one word with its strobe
  typedef struct packed {
    logic  valid;
    fixp_t data;
  } elem_stream_t;

  // Vector controller to scalar unit
  typedef struct packed {
    logic  start;
    fixp_t operand;
  } scalar_req_t;

  typedef struct packed {
    logic  ready;
    fixp_t result;
  } scalar_rsp_t;

  // Scalar unit to divider, unsigned operands
  typedef struct packed {
    logic                      start;
    logic [`TANH_DIV_BITS-1:0] dividend;
    logic [`TANH_DIV_BITS-1:0] divisor;
  } div_req_t;

  typedef struct packed {
    logic                      ready;
    logic [`TANH_DIV_BITS-1:0] quotient;
  } div_rsp_t;

endpackage

// File: src/fixed_point_divider.sv
// Iterative restoring divider for unsigned operands
// Produces one quotient bit per cycle and pulses ready with the
// truncated quotient, TANH_DIV_BITS + 1 cycles after start

`timescale 1ns/1ps
`include "tanh_defines.svh"

module fixed_point_divider
  import tanh_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  input  div_req_t req,
  output div_rsp_t rsp
);

  localparam int W     = `TANH_DIV_BITS;
  localparam int CNT_W = $clog2(W + 1);

  // Control
  logic             busy_q;
  logic             ready_q;
  logic [CNT_W-1:0] count_q;

  // Datapath
  logic [W-1:0] rem_q;
  logic [W-1:0] quot_q;
  logic [W-1:0] divisor_q;
  logic [W:0]   rem_shift;
  logic [W:0]   rem_diff;
  logic         take;

  ////////////////////////////////////////////////////////////
  // One restoring step
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Bring down the next dividend bit
    rem_shift = {rem_q, quot_q[W-1]};
    rem_diff  = rem_shift - {1'b0, divisor_q};
    // Subtract only if it does not go negative
    take      = (rem_shift >= {1'b0, divisor_q});
  end

  ////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_q  <= 1'b0;
      ready_q <= 1'b0;
      count_q <= '0;
    end else begin
      ready_q <= 1'b0;
      if (!busy_q) begin
        if (req.start) begin
          busy_q  <= 1'b1;
          count_q <= CNT_W'(W);
        end
      end else begin
        count_q <= count_q - 1'b1;
        // Last bit lands on this edge
        if (count_q == CNT_W'(1)) begin
          busy_q  <= 1'b0;
          ready_q <= 1'b1;
        end
      end
    end
  end

  // Remainder and quotient shift together, dividend bits leave from the top
  always_ff @(posedge CLK) begin
    if (!busy_q && req.start) begin
      rem_q     <= '0;
      quot_q    <= req.dividend;
      divisor_q <= req.divisor;
    end else if (busy_q) begin
      rem_q  <= take ? rem_diff[W-1:0] : rem_shift[W-1:0];
      quot_q <= {quot_q[W-2:0], take};
    end
  end

  assign rsp = '{ready: ready_q, quotient: quot_q};

endmodule

// File: src/scalar_tanh.sv
// Multi-cycle scalar tanh on one Q4.12 word
// Rational form x(27 + x^2) / (27 + 9x^2) below |x| = 3.0,
// saturation to +/-1.0 at or above it

`timescale 1ns/1ps
`include "tanh_defines.svh"

module scalar_tanh
  import tanh_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  scalar_req_t req,
  output scalar_rsp_t rsp
);

  localparam int D = `TANH_DATA_SIZE;
  localparam int W = `TANH_DIV_BITS;
  localparam int F = `TANH_FRAC_BITS;

  // 27.0 in Q.12
  localparam logic [W-1:0] C27    = W'(27 << F);
  localparam logic [D-1:0] SAT    = D'(`TANH_SAT_LIMIT);
  localparam fixp_t        ONE_P  = fixp_t'(`TANH_ONE);
  localparam fixp_t        ONE_N  = fixp_t'(-`TANH_ONE);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CHECK,
    ST_NUMDEN,
    ST_SHIFT,
    ST_DIV
  } state_t;

  state_t         state_q;
  logic           ready_q;
  logic           div_start_q;

  // Payload
  logic [D-1:0]   mag_in;
  logic [D-1:0]   mag_q;
  logic           neg_q;
  logic [W-1:0]   sq_q;
  logic [W-1:0]   num_q;
  logic [W-1:0]   den_q;
  logic [W-1:0]   dividend_q;
  logic [D-1:0]   quot16;
  fixp_t          result_q;

  div_req_t       div_req;
  div_rsp_t       div_rsp;

  // Magnitude, -32768 maps to 32768 unsigned
  assign mag_in = req.operand[D-1] ? D'(-req.operand) : D'(req.operand);
  // Quotient stays below 2^16 for |x| < 3.0
  assign quot16 = div_rsp.quotient[D-1:0];

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q     <= ST_IDLE;
      ready_q     <= 1'b0;
      div_start_q <= 1'b0;
    end else begin
      ready_q     <= 1'b0;
      div_start_q <= 1'b0;
      case (state_q)
        ST_IDLE:   if (req.start) state_q <= ST_CHECK;
        ST_CHECK: begin
          if (mag_q >= SAT) begin
            ready_q <= 1'b1;
            state_q <= ST_IDLE;
          end else begin
            state_q <= ST_NUMDEN;
          end
        end
        ST_NUMDEN: state_q <= ST_SHIFT;
        ST_SHIFT: begin
          div_start_q <= 1'b1;
          state_q     <= ST_DIV;
        end
        ST_DIV: begin
          if (div_rsp.ready) begin
            ready_q <= 1'b1;
            state_q <= ST_IDLE;
          end
        end
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Arithmetic, products truncated back to Q.12
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state_q)
      ST_IDLE: begin
        if (req.start) begin
          mag_q <= mag_in;
          neg_q <= req.operand[D-1];
        end
      end
      ST_CHECK: begin
        if (mag_q >= SAT) result_q <= neg_q ? ONE_N : ONE_P;
        // s = m*m
        sq_q <= (W'(mag_q) * W'(mag_q)) >> F;
      end
      ST_NUMDEN: begin
        num_q <= (W'(mag_q) * (C27 + sq_q)) >> F;
        // 9 is an integer factor, no rescale
        den_q <= C27 + W'(9) * sq_q;
      end
      // Pre-scale so the quotient comes out in Q.12
      ST_SHIFT: dividend_q <= num_q << F;
      ST_DIV: begin
        if (div_rsp.ready) result_q <= neg_q ? fixp_t'(-quot16) : fixp_t'(quot16);
      end
      default: ;
    endcase
  end

  // den >= 27.0, never zero
  assign div_req = '{start: div_start_q, dividend: dividend_q, divisor: den_q};

  fixed_point_divider u_divider (
    .CLK(CLK),
    .RST(RST),
    .req(div_req),
    .rsp(div_rsp)
  );

  assign rsp = '{ready: ready_q, result: result_q};

endmodule

// File: src/vector_tanh.sv
// Vector controller for the tanh stage
// Accepts one element at a time, runs it through the scalar unit and
// emits each result, with done on the last one

`timescale 1ns/1ps
`include "tanh_defines.svh"

module vector_tanh
  import tanh_pkg::*;
(
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       start,
  input  logic [`TANH_SIZE_BITS-1:0] size_in,
  input  elem_stream_t               in_elem,
  output logic                       in_ready,
  output elem_stream_t               out_elem,
  output logic                       done
);

  localparam int S = `TANH_SIZE_BITS;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_INPUT,
    ST_WAIT
  } state_t;

  state_t      state_q;
  logic [S-1:0] size_q;
  logic [S-1:0] index_q;
  logic        in_ready_q;
  logic        out_valid_q;
  logic        done_q;
  logic        scl_start_q;

  // Payload
  fixp_t       operand_q;
  fixp_t       out_data_q;

  scalar_req_t scl_req;
  scalar_rsp_t scl_rsp;
  logic        accept;
  logic        last;

  // Element handshake
  assign accept = (state_q == ST_INPUT) && in_ready_q && in_elem.valid;
  assign last   = (index_q == size_q - 1'b1);

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q     <= ST_IDLE;
      size_q      <= '0;
      index_q     <= '0;
      in_ready_q  <= 1'b0;
      out_valid_q <= 1'b0;
      done_q      <= 1'b0;
      scl_start_q <= 1'b0;
    end else begin
      // Strobes default low
      out_valid_q <= 1'b0;
      done_q      <= 1'b0;
      scl_start_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          // Start only seen here, so a busy start is dropped
          if (start) begin
            size_q     <= size_in;
            index_q    <= '0;
            in_ready_q <= 1'b1;
            state_q    <= ST_INPUT;
          end
        end
        ST_INPUT: begin
          // Re-entry after a result, ready rises one cycle later
          if (!in_ready_q) begin
            in_ready_q <= 1'b1;
          end else if (accept) begin
            in_ready_q  <= 1'b0;
            scl_start_q <= 1'b1;
            state_q     <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (scl_rsp.ready) begin
            out_valid_q <= 1'b1;
            if (last) begin
              done_q  <= 1'b1;
              state_q <= ST_IDLE;
            end else begin
              index_q <= index_q + 1'b1;
              state_q <= ST_INPUT;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Operand held until the scalar unit answers
  always_ff @(posedge CLK) begin
    if (accept) operand_q <= in_elem.data;
    if ((state_q == ST_WAIT) && scl_rsp.ready) out_data_q <= scl_rsp.result;
  end

  assign scl_req = '{start: scl_start_q, operand: operand_q};

  scalar_tanh u_scalar (
    .CLK(CLK),
    .RST(RST),
    .req(scl_req),
    .rsp(scl_rsp)
  );

  assign in_ready = in_ready_q;
  assign out_elem = '{valid: out_valid_q, data: out_data_q};
  assign done     = done_q;

endmodule

// File: src/ntm_tanh_top.sv
// Top level of the tanh activation stage
// Exposes the vector start, element and result streams

`timescale 1ns/1ps
`include "tanh_defines.svh"

module ntm_tanh_top
  import tanh_pkg::*;
(
  // Global
  input  logic                       CLK,
  input  logic                       RST,

  // Vector control
  input  logic                       start,
  input  logic [`TANH_SIZE_BITS-1:0] size_in,

  // Element input, transfers on valid and in_ready
  input  elem_stream_t               in_elem,
  output logic                       in_ready,

  // Results, no back-pressure
  output elem_stream_t               out_elem,
  output logic                       done
);

  ////////////////////////////////////////////////////////////
  // Vector controller
  ////////////////////////////////////////////////////////////

  vector_tanh u_vector (
    .CLK     (CLK),
    .RST     (RST),
    .start   (start),
    .size_in (size_in),
    .in_elem (in_elem),
    .in_ready(in_ready),
    .out_elem(out_elem),
    .done    (done)
  );

endmodule

// File: verification/tanh_checker.sv
// Protocol assertions for the tanh activation stage
// Bound to the top level to watch reset, result and ready strobes

`timescale 1ns/1ps

module tanh_checker
  import tanh_pkg::*;
(
  input logic         CLK,
  input logic         RST,
  input logic         in_ready,
  input logic         done,
  input elem_stream_t out_elem
);

  // Count of failed assertions
  int assert_failures = 0;

  // Everything quiet while in reset
  reset_quiet: assert property (@(posedge CLK)
    RST |-> (!in_ready && !done && !out_elem.valid))
    else begin
      $error("handshake outputs active during reset");
      assert_failures++;
    end

  // done only rides on a result
  done_with_result: assert property (@(posedge CLK) disable iff (RST)
    done |-> out_elem.valid)
    else begin
      $error("done raised without a result");
      assert_failures++;
    end

  // Single-cycle result strobe
  result_one_cycle: assert property (@(posedge CLK) disable iff (RST)
    out_elem.valid |=> !out_elem.valid)
    else begin
      $error("result valid held longer than one cycle");
      assert_failures++;
    end

  // Input side closed while a result leaves
  ready_not_with_result: assert property (@(posedge CLK) disable iff (RST)
    !(in_ready && out_elem.valid))
    else begin
      $error("in_ready high in a result cycle");
      assert_failures++;
    end

endmodule

bind ntm_tanh_top tanh_checker u_checker (
  .CLK     (CLK),
  .RST     (RST),
  .in_ready(in_ready),
  .done    (done),
  .out_elem(out_elem)
);

// File: verification/tanh_tb.sv
// Directed testbench for the tanh activation stage
// Drives vectors through the top level and checks every result
// against a bit-exact model of the rational approximation

`timescale 1ns/1ps
`include "tanh_defines.svh"

module tanh_tb
  import tanh_pkg::*;
();

  logic                       CLK;
  logic                       RST;
  logic                       start;
  logic [`TANH_SIZE_BITS-1:0] size_in;
  elem_stream_t               in_elem;
  logic                       in_ready;
  elem_stream_t               out_elem;
  logic                       done;

  int value_errors;
  int other_errors;
  int assertion_errors;
  int strobe_count;
  int done_count;
  int seed;

  ntm_tanh_top dut0 (.*);

  // 100 ns period
  always #50 CLK = ~CLK;

  // Strobe tally sampled mid-cycle
  always @(negedge CLK) begin
    if (!RST && out_elem.valid) strobe_count++;
    if (!RST && done) done_count++;
  end

  ////////////////////////////////////////////////////////////
  // Model and compare helpers
  ////////////////////////////////////////////////////////////

  // Q4.12 rational tanh with products truncated to Q.12
  function automatic fixp_t tanh_model(input fixp_t x);
    longint m;
    longint s;
    longint c27;
    longint num;
    longint den;
    longint q;
    c27 = 27 << `TANH_FRAC_BITS;
    m   = (x < 0) ? -longint'(x) : longint'(x);
    if (m >= `TANH_SAT_LIMIT) return (x < 0) ? fixp_t'(-`TANH_ONE) : fixp_t'(`TANH_ONE);
    s   = (m * m) >> `TANH_FRAC_BITS;
    num = (m * (c27 + s)) >> `TANH_FRAC_BITS;
    den = c27 + 9 * s;
    q   = (num << `TANH_FRAC_BITS) / den;
    return (x < 0) ? fixp_t'(-q) : fixp_t'(q);
  endfunction

  task automatic compare_fixp(input string name, input fixp_t got, input fixp_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    other_errors++;
    $display("FAILURE: %s", what);
  endtask

  ////////////////////////////////////////////////////////////
  // Handshake tasks
  ////////////////////////////////////////////////////////////

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    do begin
      @(negedge CLK);
      cycles++;
    end while (!in_ready && cycles < 200);
    if (!in_ready) report_failure("in_ready never rose within 200 cycles");
  endtask

  task automatic collect_result(input fixp_t exp, input logic exp_done);
    int cycles;
    cycles = 0;
    do begin
      @(negedge CLK);
      cycles++;
    end while (!out_elem.valid && cycles < 200);
    if (!out_elem.valid) begin
      report_failure("no result strobe within 200 cycles");
    end else begin
      compare_fixp("out_elem.data", out_elem.data, exp);
      compare_bit("done", done, exp_done);
    end
  endtask

  // Runs one vector through the DUT
  // early holds each element valid before in_ready rises
  // busy pulses a second start while the first element is in flight
  task automatic run_vector(input fixp_t ops[$], input int gap, input logic early,
                            input logic busy);
    int n;
    int strobes0;
    int dones0;
    n        = ops.size();
    strobes0 = strobe_count;
    dones0   = done_count;
    @(posedge CLK);
    start   <= 1'b1;
    size_in <= `TANH_SIZE_BITS'(n);
    if (early) in_elem <= '{valid: 1'b1, data: ops[0]};
    @(posedge CLK);
    start <= 1'b0;
    for (int i = 0; i < n; i++) begin
      if (!early) begin
        repeat (gap + 1) @(posedge CLK);
        in_elem <= '{valid: 1'b1, data: ops[i]};
      end
      wait_ready();
      // Transfer edge
      @(posedge CLK);
      if (early && i < n - 1) in_elem <= '{valid: 1'b1, data: ops[i + 1]};
      else in_elem <= '0;
      if (busy && i == 0) begin
        start   <= 1'b1;
        size_in <= 8'd200;
        @(posedge CLK);
        start <= 1'b0;
      end
      collect_result(tanh_model(ops[i]), i == n - 1);
    end
    // Idle again with nothing extra
    repeat (5) @(negedge CLK);
    compare_bit("in_ready", in_ready, 1'b0);
    @(posedge CLK);
    if (strobe_count - strobes0 != n)
      report_failure($sformatf("expected %0d result strobes, saw %0d",
                               n, strobe_count - strobes0));
    if (done_count - dones0 != 1)
      report_failure($sformatf("expected one done strobe, saw %0d", done_count - dones0));
  endtask

  function automatic fixp_t random_operand();
    int r;
    // Range just inside +/-4.0
    r = $random(seed) % 16384;
    return fixp_t'(r);
  endfunction

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic idle_after_reset();
    repeat (20) begin
      @(negedge CLK);
      compare_bit("in_ready", in_ready, 1'b0);
      compare_bit("done", done, 1'b0);
      compare_bit("out_elem.valid", out_elem.valid, 1'b0);
    end
  endtask

  task automatic fixed_operand_vectors();
    fixp_t fixed_ops[7] = '{16'sd0, 16'sd2048, 16'sd14336, -16'sd16384,
                            16'sd12288, -16'sd12288, -16'sd2048};
    fixp_t one_op[$];
    foreach (fixed_ops[k]) begin
      one_op.delete();
      one_op.push_back(fixed_ops[k]);
      run_vector(one_op, 0, 1'b0, 1'b0);
    end
  endtask

  task automatic random_vector(input int n, input int gap, input logic early);
    fixp_t ops[$];
    repeat (n) ops.push_back(random_operand());
    run_vector(ops, gap, early, 1'b0);
  endtask

  task automatic back_to_back_vectors();
    fixp_t first[$];
    fixp_t second[$];
    repeat (4) first.push_back(random_operand());
    repeat (3) second.push_back(random_operand());
    // Busy start dropped so only four results are expected
    run_vector(first, 0, 1'b0, 1'b1);
    run_vector(second, 0, 1'b0, 1'b0);
  endtask

  initial begin
    CLK              = 1'b0;
    RST              = 1'b1;
    start            = 1'b0;
    size_in          = '0;
    in_elem          = '0;
    value_errors     = 0;
    other_errors     = 0;
    assertion_errors = 0;
    strobe_count     = 0;
    done_count       = 0;
    seed             = 32'hcbcf;
    repeat (16) @(posedge CLK);
    RST <= 1'b0;

    idle_after_reset();
    fixed_operand_vectors();
    random_vector(16, 0, 1'b0);
    random_vector(7, 2, 1'b0);
    random_vector(8, 0, 1'b1);
    back_to_back_vectors();

    assertion_errors = dut0.u_checker.assert_failures;
    $display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
             value_errors, other_errors, assertion_errors);
    if (value_errors == 0 && other_errors == 0 && assertion_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+src
src/tanh_pkg.sv
src/fixed_point_divider.sv
src/scalar_tanh.sv
src/vector_tanh.sv
src/ntm_tanh_top.sv
verification/tanh_checker.sv
verification/tanh_tb.sv
